//--- include/covar_consts.svh
`ifndef COVAR_CONSTS_SVH
`define COVAR_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// array geometry and datapath widths
//////////////////////////////////////////////////////////////////////

// channels per sample vector
`define COVAR_NUM_CH 4

// re and im width of one input sample
`define COVAR_SAMPLE_W 16

// re and im width of products and sums, wraps mod 2^32
`define COVAR_ACC_W 32

// complex_mult pipeline depth in cycles
`define COVAR_MULT_LAT 2

`endif

//--- source/covar_pkg.sv
`include "covar_consts.svh"

package covar_pkg;

  // one channel sample, im in the upper half
  typedef struct packed {
    logic signed [`COVAR_SAMPLE_W-1:0] im;
    logic signed [`COVAR_SAMPLE_W-1:0] re;
  } cplx_sample_t;

  // product / accumulator entry, same ordering
  typedef struct packed {
    logic signed [`COVAR_ACC_W-1:0] im;
    logic signed [`COVAR_ACC_W-1:0] re;
  } cplx_acc_t;

  // one sample per channel
  typedef cplx_sample_t [`COVAR_NUM_CH-1:0] sample_vec_t;

  // [row i][col j], entry holds sum of x_i * conj(x_j)
  typedef cplx_acc_t [`COVAR_NUM_CH-1:0][`COVAR_NUM_CH-1:0] cov_matrix_t;

endpackage

//--- source/complex_mult.sv
`timescale 1ns/1ps
`include "covar_consts.svh"

module complex_mult
  import covar_pkg::*;
(
  input  logic         clk,
  input  logic         reset_n,
  input  cplx_sample_t a,
  input  cplx_sample_t b,
  input  logic         valid,
  input  logic         last,
  output cplx_acc_t    p,
  output logic         p_valid,
  output logic         p_last
);

  logic signed [`COVAR_ACC_W-1:0] rr_q;  // a.re * b.re
  logic signed [`COVAR_ACC_W-1:0] ii_q;  // a.im * b.im
  logic signed [`COVAR_ACC_W-1:0] ri_q;  // a.re * b.im
  logic signed [`COVAR_ACC_W-1:0] ir_q;  // a.im * b.re
  logic                           valid_q;  // stage one sideband
  logic                           last_q;

  //////////////////////////////////////////////////////////////////////
  // stage one: partial products
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= valid;
      last_q  <= last;                  // flag travels with the data
    end
  end

  always_ff @(posedge clk) begin
    rr_q <= a.re * b.re;                // 16x16 signed, exact in 32
    ii_q <= a.im * b.im;
    ri_q <= a.re * b.im;
    ir_q <= a.im * b.re;
  end

  //////////////////////////////////////////////////////////////////////
  // stage two: combine, wraps mod 2^32
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      p_valid <= 1'b0;
      p_last  <= 1'b0;
    end else begin
      p_valid <= valid_q;
      p_last  <= last_q;
    end
  end

  always_ff @(posedge clk) begin
    p.re <= rr_q - ii_q;                // re*re - im*im
    p.im <= ri_q + ir_q;                // cross terms
  end

  // last flag only ever rides on a valid product
  a_last_needs_valid : assert property (
    @(posedge clk) disable iff (!reset_n) p_last |-> p_valid
  );

endmodule

//--- source/outer_product_array.sv
`timescale 1ns/1ps
`include "covar_consts.svh"

module outer_product_array
  import covar_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        in_valid,
  input  logic        in_last,
  input  sample_vec_t in_samples,
  output logic        prod_valid,
  output logic        prod_last,
  output cov_matrix_t prod_matrix
);

  sample_vec_t conj_samples;  // conj(x_j), no register

  // negate im mod 2^16, -32768 maps to itself
  for (genvar j = 0; j < `COVAR_NUM_CH; j++) begin : g_conj
    assign conj_samples[j].re = in_samples[j].re;
    assign conj_samples[j].im = -in_samples[j].im;
  end

  //////////////////////////////////////////////////////////////////////
  // 4x4 multiplier grid, entry (i,j) = x_i * conj(x_j)
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `COVAR_NUM_CH; i++) begin : g_row
    for (genvar j = 0; j < `COVAR_NUM_CH; j++) begin : g_col
      if (i == 0 && j == 0) begin : g_lead
        complex_mult u_mult (             // sideband source for the grid
          .clk     (clk),
          .reset_n (reset_n),
          .a       (in_samples[i]),
          .b       (conj_samples[j]),
          .valid   (in_valid),
          .last    (in_last),
          .p       (prod_matrix[i][j]),
          .p_valid (prod_valid),
          .p_last  (prod_last)
        );
      end else begin : g_rest
        complex_mult u_mult (             // same timing as (0,0)
          .clk     (clk),
          .reset_n (reset_n),
          .a       (in_samples[i]),
          .b       (conj_samples[j]),
          .valid   (in_valid),
          .last    (in_last),
          .p       (prod_matrix[i][j]),
          .p_valid (),
          .p_last  ()
        );
      end
    end
  end

  // a closing sample leaves the grid after the full multiplier depth
  a_last_latency : assert property (
    @(posedge clk) disable iff (!reset_n)
    (in_valid && in_last) |-> ##(`COVAR_MULT_LAT) (prod_valid && prod_last)
  );

endmodule

//--- source/cov_accumulator.sv
`timescale 1ns/1ps
`include "covar_consts.svh"

module cov_accumulator
  import covar_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        prod_valid,
  input  logic        prod_last,
  input  cov_matrix_t prod_matrix,
  output logic        out_valid,
  output cov_matrix_t cov_matrix
);

  cov_matrix_t acc_q;         // running sums of the open frame
  cov_matrix_t acc_next;      // acc plus product or product alone
  logic        frame_open_q;  // a frame has started and not closed

  //////////////////////////////////////////////////////////////////////
  // per-entry adders
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `COVAR_NUM_CH; i++) begin : g_row
    for (genvar j = 0; j < `COVAR_NUM_CH; j++) begin : g_col
      cplx_acc_t base;  // zero on the first product of a frame

      assign base = frame_open_q ? acc_q[i][j] : '0;

      // components wrap independently mod 2^32
      assign acc_next[i][j].re = base.re + prod_matrix[i][j].re;
      assign acc_next[i][j].im = base.im + prod_matrix[i][j].im;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // accumulators and frame tracking
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      acc_q        <= '0;
      frame_open_q <= 1'b0;
    end else if (prod_valid) begin
      acc_q        <= acc_next;
      frame_open_q <= !prod_last;  // last closes and the next one restarts
    end
  end

  //////////////////////////////////////////////////////////////////////
  // result register and strobe
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= prod_valid && prod_last;  // one cycle per frame
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cov_matrix <= '0;
    end else if (prod_valid && prod_last) begin
      cov_matrix <= acc_next;  // holds until the next close
    end
  end

  // upstream grid never flags last on an idle cycle
  a_last_with_valid : assert property (
    @(posedge clk) disable iff (!reset_n) prod_last |-> prod_valid
  );

endmodule

//--- source/covar_est_top.sv
`timescale 1ns/1ps

module covar_est_top
  import covar_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        in_valid,
  input  logic        in_last,
  input  sample_vec_t in_samples,
  output logic        out_valid,
  output cov_matrix_t cov_matrix
);

  //////////////////////////////////////////////////////////////////////
  // product path between grid and accumulator
  //////////////////////////////////////////////////////////////////////

  logic        prod_valid;   // in_valid delayed by the multiplier depth
  logic        prod_last;    // frame close marker, same delay
  cov_matrix_t prod_matrix;  // x * x^H for one sample vector

  // conjugate and multiply, two cycles
  outer_product_array u_array (
    .clk         (clk),
    .reset_n     (reset_n),
    .in_valid    (in_valid),
    .in_last     (in_last),
    .in_samples  (in_samples),
    .prod_valid  (prod_valid),
    .prod_last   (prod_last),
    .prod_matrix (prod_matrix)
  );

  // sum over the frame, one more cycle to the outputs
  cov_accumulator u_acc (
    .clk         (clk),
    .reset_n     (reset_n),
    .prod_valid  (prod_valid),
    .prod_last   (prod_last),
    .prod_matrix (prod_matrix),
    .out_valid   (out_valid),
    .cov_matrix  (cov_matrix)
  );

endmodule

//--- sim/covar_est_tb.sv
`timescale 1ns/1ps
`include "covar_consts.svh"

module covar_est_tb
  import covar_pkg::*;
();

  localparam int CLK_HALF       = 20;  // 40 ns period
  localparam int STROBE_TIMEOUT = 60;  // cycles per wait for out_valid

  logic        clk;
  logic        reset_n;
  logic        in_valid;
  logic        in_last;
  sample_vec_t in_samples;
  logic        out_valid;
  cov_matrix_t cov_matrix;

  cov_matrix_t exp_mat [0:63];   // model sum per frame index
  cov_matrix_t exp_head;         // frame the next strobe reports
  int          cur_frame;        // index of the frame being sent
  int          frame_len;        // samples sent in that frame so far
  int          strobe_cnt = 0;   // strobes seen since reset
  logic        before_input;     // no valid sample sent yet
  logic [31:0] rng_state;
  int          value_errs;
  int          timing_errs;
  int          other_errs;

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  covar_est_top dut0 (
    .clk        (clk),
    .reset_n    (reset_n),
    .in_valid   (in_valid),
    .in_last    (in_last),
    .in_samples (in_samples),
    .out_valid  (out_valid),
    .cov_matrix (cov_matrix)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // x * x^H at full precision and cut to 32 bits
  function automatic cov_matrix_t outer_model(input sample_vec_t x);
    cov_matrix_t m;
    longint      cj_im;
    longint      re_full;
    longint      im_full;
    for (int i = 0; i < `COVAR_NUM_CH; i++) begin
      for (int j = 0; j < `COVAR_NUM_CH; j++) begin
        cj_im = -longint'(x[j].im);
        if (cj_im == 32768) cj_im = -32768;  // 16-bit negation wraps
        re_full = longint'(x[i].re) * longint'(x[j].re) - longint'(x[i].im) * cj_im;
        im_full = longint'(x[i].re) * cj_im + longint'(x[i].im) * longint'(x[j].re);
        m[i][j].re = re_full[31:0];
        m[i][j].im = im_full[31:0];
      end
    end
    return m;
  endfunction

  function automatic cov_matrix_t add_wrap(input cov_matrix_t a, input cov_matrix_t b);
    cov_matrix_t s;
    for (int i = 0; i < `COVAR_NUM_CH; i++) begin
      for (int j = 0; j < `COVAR_NUM_CH; j++) begin
        s[i][j].re = a[i][j].re + b[i][j].re;  // mod 2^32
        s[i][j].im = a[i][j].im + b[i][j].im;
      end
    end
    return s;
  endfunction

  always_comb exp_head = exp_mat[strobe_cnt];

  always @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      strobe_cnt <= 0;
    end else if (out_valid) begin
      strobe_cnt <= strobe_cnt + 1;  // next frame becomes the head
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  a_quiet_after_reset : assert property (
    @(posedge clk) disable iff (!reset_n)
    before_input |-> (!out_valid && cov_matrix == '0)
  ) else begin
    value_errs++;
    $display("[ERROR] %0t ns: outputs not idle and zero before any input", $time);
  end

  a_matrix_value : assert property (
    @(posedge clk) disable iff (!reset_n) out_valid |-> (cov_matrix == exp_head)
  ) else begin
    value_errs++;
    $display("[ERROR] %0t ns: cov_matrix differs from the model sum of its frame", $time);
  end

  a_hold_between : assert property (
    @(posedge clk) disable iff (!reset_n) !out_valid |-> $stable(cov_matrix)
  ) else begin
    value_errs++;
    $display("[ERROR] %0t ns: cov_matrix changed without a strobe", $time);
  end

  a_strobe_delay : assert property (
    @(posedge clk) disable iff (!reset_n) (in_valid && in_last) |-> ##3 out_valid
  ) else begin
    timing_errs++;
    $display("out_valid missing 3 cycles after a last sample at %0t ns", $time);
  end

  a_no_stray_strobe : assert property (
    @(posedge clk) disable iff (!reset_n) out_valid |-> $past(in_valid && in_last, 3)
  ) else begin
    timing_errs++;
    $display("out_valid raised with no last sample 3 cycles earlier, at %0t ns", $time);
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic next_rand(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  task automatic rand_vec(output sample_vec_t v);
    logic [31:0] r;
    for (int c = 0; c < `COVAR_NUM_CH; c++) begin
      next_rand(r);
      v[c] = r;
    end
  endtask

  // samples change every cycle but in_valid stays low
  task automatic idle_cycles(input int n);
    sample_vec_t junk;
    for (int k = 0; k < n; k++) begin
      rand_vec(junk);
      @(negedge clk);
      in_valid   = 1'b0;
      in_last    = 1'b0;
      in_samples = junk;
    end
  endtask

  task automatic send_sample(input sample_vec_t x, input logic last);
    cov_matrix_t prod;
    prod = outer_model(x);
    if (frame_len == 0) begin
      exp_mat[cur_frame] = prod;  // first sample restarts the sum
    end else begin
      exp_mat[cur_frame] = add_wrap(exp_mat[cur_frame], prod);
    end
    frame_len++;
    @(negedge clk);
    before_input = 1'b0;
    in_valid     = 1'b1;
    in_last      = last;
    in_samples   = x;
    if (last) begin
      cur_frame++;
      frame_len = 0;
    end
  endtask

  task automatic wait_all_strobes(output bit ok);
    int waited;
    waited = 0;
    while (strobe_cnt < cur_frame && waited < STROBE_TIMEOUT) begin
      idle_cycles(1);
      waited++;
    end
    ok = (strobe_cnt >= cur_frame);
  endtask

  task automatic run_tests();
    sample_vec_t v;
    logic [31:0] r;
    int          len;
    bit          ok;
    idle_cycles(5);                   // nothing sent yet
    rand_vec(v);
    send_sample(v, 1'b1);             // one-sample frame
    wait_all_strobes(ok);
    if (!ok) return;
    next_rand(r);
    len = 6 + int'(r % 7);
    for (int k = 0; k < len; k++) begin
      rand_vec(v);
      send_sample(v, k == len - 1);
      next_rand(r);
      if (k != len - 1) idle_cycles(int'(r % 4));  // gaps inside the frame
    end
    wait_all_strobes(ok);
    if (!ok) return;
    for (int k = 0; k < 6; k++) begin  // frames of 3, 1 and 2 without gaps
      rand_vec(v);
      send_sample(v, k == 2 || k == 3 || k == 5);
    end
    wait_all_strobes(ok);
    if (!ok) return;
    v[0].re = 16'h8000;
    v[0].im = 16'h8000;
    v[1].re = 16'h7fff;
    v[1].im = 16'h7fff;
    v[2].re = 16'h8000;
    v[2].im = 16'h7fff;
    v[3].re = 16'h7fff;
    v[3].im = 16'h8000;
    send_sample(v, 1'b0);             // sums wrap past 2^31
    send_sample(v, 1'b0);
    send_sample(v, 1'b1);
    send_sample(v, 1'b1);
    wait_all_strobes(ok);
    if (!ok) return;
    idle_cycles(12);                  // result must hold
  endtask

  initial begin
    reset_n      = 1'b0;
    in_valid     = 1'b0;
    in_last      = 1'b0;
    in_samples   = '0;
    before_input = 1'b1;
    rng_state    = 32'd26;
    cur_frame    = 0;
    frame_len    = 0;
    value_errs   = 0;
    timing_errs  = 0;
    other_errs   = 0;
    repeat (3) @(negedge clk);
    reset_n = 1'b1;
    run_tests();
    if (strobe_cnt < cur_frame) begin
      other_errs++;
      $display("timeout: out_valid did not report all %0d frames", cur_frame);
    end
    $display("errors: value %0d, timing %0d, other %0d, frames %0d, strobes %0d",
             value_errs, timing_errs, other_errs, cur_frame, strobe_cnt);
    if (value_errs == 0 && timing_errs == 0 && other_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- covar_est.f
+incdir+include
source/covar_pkg.sv
source/complex_mult.sv
source/outer_product_array.sv
source/cov_accumulator.sv
source/covar_est_top.sv
sim/covar_est_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the covariance estimator testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

TOP=covar_est_tb
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  --top-module "$TOP" \
  -f covar_est.f \
  --Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TEST PASSED" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
